// ==== hw/datapath_cfg.svh ====
`ifndef DATAPATH_CFG_SVH
`define DATAPATH_CFG_SVH

// Width of every bus word and register
`define DP_WIDTH 32

// General purpose registers R0..R15
`define DP_NREGS 16

// ALU opcode field width
`define DP_OPW 5

`endif

// ==== hw/datapath_pkg.sv ====
`include "datapath_cfg.svh"

package datapath_pkg;

	typedef enum logic [`DP_OPW-1:0] {
		opAdd   = 5'd0,
		opSub   = 5'd1,
		opAnd   = 5'd2,
		opOr    = 5'd3,
		opShr   = 5'd4,
		opShra  = 5'd5,
		opShl   = 5'd6,
		opRor   = 5'd7,
		opRol   = 5'd8,
		opMul   = 5'd9,
		opDiv   = 5'd10,
		opNeg   = 5'd11,
		opNot   = 5'd12,
		opIncPc = 5'd13
	} aluOp_e;

	// What drives the bus this cycle
	typedef enum logic [4:0] {
		srcNone,
		srcReg,
		srcHi,
		srcLo,
		srcZHi,
		srcZLo,
		srcPc,
		srcMdr,
		srcInport,
		srcC
	} busSrc_e;

	typedef struct packed {
		logic gra;
		logic grb;
		logic grc;
		logic rIn;
		logic rOut;
		logic baOut;
	} regStrobe_s;

	typedef struct packed {
		logic pcIn;
		logic irIn;
		logic ryIn;
		logic rzIn;
		logic hiIn;
		logic loIn;
		logic marIn;
		logic mdrIn;
		logic inportIn;
		logic outportIn;
		logic incPc;
	} loadStrobe_s;

	typedef struct packed {
		logic hiOut;
		logic loOut;
		logic zHiOut;
		logic zLoOut;
		logic pcOut;
		logic mdrOut;
		logic inportOut;
		logic cOut;
	} outStrobe_s;

	// One full control word, supplied from outside every cycle
	typedef struct packed {
		regStrobe_s  regStrobe;
		loadStrobe_s loadStrobe;
		outStrobe_s  outStrobe;
		logic        memRead;
		aluOp_e      aluOp;
	} controlWord_s;

	typedef struct packed {
		logic [4:0]  opcode;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [3:0]  rc;
		logic [14:0] unused;
	} rForm_s;

	typedef struct packed {
		logic [4:0]  opcode;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [18:0] constant;
	} iForm_s;

	// Same IR word, register form or immediate form
	typedef union packed {
		rForm_s rForm;
		iForm_s iForm;
	} irWord_u;

	typedef struct packed {
		logic [`DP_WIDTH-1:0] zHi;
		logic [`DP_WIDTH-1:0] zLo;
		logic [`DP_WIDTH-1:0] hi;
		logic [`DP_WIDTH-1:0] lo;
		logic [`DP_WIDTH-1:0] pc;
		logic [`DP_WIDTH-1:0] mdr;
		logic [`DP_WIDTH-1:0] inport;
	} specialView_s;

endpackage

// ==== hw/busMux.sv ====
`include "datapath_cfg.svh"

module busMux (
	output logic [`DP_WIDTH-1:0]      bus,
	input  datapath_pkg::outStrobe_s  outStrobe,
	input  logic                      regRdValid,
	input  logic [`DP_WIDTH-1:0]      regRdData,
	input  datapath_pkg::specialView_s special,
	input  logic [`DP_WIDTH-1:0]      cSignExt
);

	datapath_pkg::busSrc_e src;

	// Strobes are one-hot by rule, so the order here only matters on misuse
	always_comb begin
		if (regRdValid)               src = datapath_pkg::srcReg;
		else if (outStrobe.hiOut)     src = datapath_pkg::srcHi;
		else if (outStrobe.loOut)     src = datapath_pkg::srcLo;
		else if (outStrobe.zHiOut)    src = datapath_pkg::srcZHi;
		else if (outStrobe.zLoOut)    src = datapath_pkg::srcZLo;
		else if (outStrobe.pcOut)     src = datapath_pkg::srcPc;
		else if (outStrobe.mdrOut)    src = datapath_pkg::srcMdr;
		else if (outStrobe.inportOut) src = datapath_pkg::srcInport;
		else if (outStrobe.cOut)      src = datapath_pkg::srcC;
		else                          src = datapath_pkg::srcNone;
	end

	always_comb begin
		case (src)
			datapath_pkg::srcReg:    bus = regRdData;
			datapath_pkg::srcHi:     bus = special.hi;
			datapath_pkg::srcLo:     bus = special.lo;
			datapath_pkg::srcZHi:    bus = special.zHi;
			datapath_pkg::srcZLo:    bus = special.zLo;
			datapath_pkg::srcPc:     bus = special.pc;
			datapath_pkg::srcMdr:    bus = special.mdr;
			datapath_pkg::srcInport: bus = special.inport;
			datapath_pkg::srcC:      bus = cSignExt;
			default:                 bus = '0;
		endcase
	end

endmodule

// ==== hw/registerFile.sv ====
`include "datapath_cfg.svh"

module registerFile (
	input  logic                         clock,
	input  logic                         rstN,
	input  logic [`DP_NREGS-1:0]         wrEn,
	input  logic [$clog2(`DP_NREGS)-1:0] rdSel,
	input  logic                         baOut,
	input  logic [`DP_WIDTH-1:0]         bus,
	output logic [`DP_WIDTH-1:0]         rdData
);

	logic [`DP_WIDTH-1:0] regs [`DP_NREGS];

	genvar i;
	generate
		for (i = 0; i < `DP_NREGS; i++) begin : gReg
			always_ff @(posedge clock) begin
				if (!rstN) begin
					regs[i] <= '0;
				end else if (wrEn[i]) begin
					regs[i] <= bus;
				end
			end
		end
	endgenerate

	// Base address read of R0 gives zero, plain rOut still sees R0
	always_comb begin
		if (baOut && rdSel == '0) begin
			rdData = '0;
		end else begin
			rdData = regs[rdSel];
		end
	end

endmodule

// ==== hw/selectEncode.sv ====
`include "datapath_cfg.svh"

module selectEncode (
	input  datapath_pkg::irWord_u        ir,
	input  datapath_pkg::regStrobe_s     regStrobe,
	output logic [`DP_NREGS-1:0]         wrEn,
	output logic [$clog2(`DP_NREGS)-1:0] rdSel,
	output logic                         rdValid,
	output logic [`DP_WIDTH-1:0]         cSignExt
);

	localparam int ConstW = $bits(ir.iForm.constant);

	logic [$clog2(`DP_NREGS)-1:0] field;

	// Pick which IR register field addresses the file
	always_comb begin
		if (regStrobe.gra) begin
			field = ir.rForm.ra;
		end else if (regStrobe.grb) begin
			field = ir.rForm.rb;
		end else if (regStrobe.grc) begin
			field = ir.rForm.rc;
		end else begin
			field = '0;
		end
	end

	// One-hot write enable
	always_comb begin
		wrEn = '0;
		if (regStrobe.rIn) begin
			wrEn[field] = 1'b1;
		end
	end

	assign rdSel   = field;
	assign rdValid = regStrobe.rOut | regStrobe.baOut;

	// Immediate view of the same word
	assign cSignExt = {{(`DP_WIDTH-ConstW){ir.iForm.constant[ConstW-1]}}, ir.iForm.constant};

endmodule

// ==== hw/alu.sv ====
`include "datapath_cfg.svh"

module alu (
	input  logic [`DP_WIDTH-1:0]   a,
	input  logic [`DP_WIDTH-1:0]   b,
	input  datapath_pkg::aluOp_e   op,
	input  logic                   incPc,
	output logic [2*`DP_WIDTH-1:0] result
);

	localparam int ShW = $clog2(`DP_WIDTH);

	logic [ShW-1:0]                shamt;
	logic [2*`DP_WIDTH-1:0]        rorWord;
	logic [2*`DP_WIDTH-1:0]        rolWord;
	logic signed [2*`DP_WIDTH-1:0] product;
	logic signed [`DP_WIDTH-1:0]   quotient;
	logic signed [`DP_WIDTH-1:0]   remainder;

	// Shift count comes from the bus operand
	assign shamt = b[ShW-1:0];

	// Doubled word makes rotates plain shifts
	assign rorWord = {a, a} >> shamt;
	assign rolWord = {a, a} << shamt;

	assign product = $signed(a) * $signed(b);

	// Divide by zero: all ones quotient, dividend kept as remainder
	always_comb begin
		if (b == '0) begin
			quotient  = '1;
			remainder = a;
		end else begin
			quotient  = $signed(a) / $signed(b);
			remainder = $signed(a) % $signed(b);
		end
	end

	always_comb begin
		result = '0;
		if (incPc) begin
			result[`DP_WIDTH-1:0] = b + 1'b1;
		end else begin
			case (op)
				datapath_pkg::opAdd:   result[`DP_WIDTH-1:0] = a + b;
				datapath_pkg::opSub:   result[`DP_WIDTH-1:0] = a - b;
				datapath_pkg::opAnd:   result[`DP_WIDTH-1:0] = a & b;
				datapath_pkg::opOr:    result[`DP_WIDTH-1:0] = a | b;
				datapath_pkg::opShr:   result[`DP_WIDTH-1:0] = a >> shamt;
				datapath_pkg::opShra:  result[`DP_WIDTH-1:0] = $signed(a) >>> shamt;
				datapath_pkg::opShl:   result[`DP_WIDTH-1:0] = a << shamt;
				datapath_pkg::opRor:   result[`DP_WIDTH-1:0] = rorWord[`DP_WIDTH-1:0];
				datapath_pkg::opRol:   result[`DP_WIDTH-1:0] = rolWord[2*`DP_WIDTH-1:`DP_WIDTH];
				datapath_pkg::opMul:   result = product;
				datapath_pkg::opDiv:   result = {remainder, quotient};
				// Unary ops work on the bus operand
				datapath_pkg::opNeg:   result[`DP_WIDTH-1:0] = -b;
				datapath_pkg::opNot:   result[`DP_WIDTH-1:0] = ~b;
				datapath_pkg::opIncPc: result[`DP_WIDTH-1:0] = b + 1'b1;
				default:               result = '0;
			endcase
		end
	end

endmodule

// ==== hw/specialRegs.sv ====
`include "datapath_cfg.svh"

module specialRegs (
	input  logic                        clock,
	input  logic                        rstN,
	input  datapath_pkg::loadStrobe_s   load,
	input  logic                        memRead,
	input  logic [`DP_WIDTH-1:0]        bus,
	input  logic [`DP_WIDTH-1:0]        memData,
	input  logic [`DP_WIDTH-1:0]        inportData,
	input  logic [2*`DP_WIDTH-1:0]      aluResult,
	output datapath_pkg::irWord_u       ir,
	output logic [`DP_WIDTH-1:0]        ry,
	output datapath_pkg::specialView_s  view,
	output logic [`DP_WIDTH-1:0]        marAddr,
	output logic [`DP_WIDTH-1:0]        outportData
);

	logic [`DP_WIDTH-1:0] pc;
	logic [`DP_WIDTH-1:0] zHi;
	logic [`DP_WIDTH-1:0] zLo;
	logic [`DP_WIDTH-1:0] hi;
	logic [`DP_WIDTH-1:0] lo;
	logic [`DP_WIDTH-1:0] mdr;
	logic [`DP_WIDTH-1:0] inport;
	logic [`DP_WIDTH-1:0] mdrNext;

	// MDR takes memory on a read, the bus otherwise
	assign mdrNext = memRead ? memData : bus;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			pc          <= '0;
			ir          <= '0;
			ry          <= '0;
			zHi         <= '0;
			zLo         <= '0;
			hi          <= '0;
			lo          <= '0;
			marAddr     <= '0;
			mdr         <= '0;
			inport      <= '0;
			outportData <= '0;
		end else begin
			if (load.pcIn)      pc          <= bus;
			if (load.irIn)      ir          <= bus;
			if (load.ryIn)      ry          <= bus;
			if (load.hiIn)      hi          <= bus;
			if (load.loIn)      lo          <= bus;
			if (load.marIn)     marAddr     <= bus;
			if (load.mdrIn)     mdr         <= mdrNext;
			if (load.outportIn) outportData <= bus;
			// Inport samples the pins, not the bus
			if (load.inportIn)  inport      <= inportData;
			// Both Z halves take the ALU result of this cycle
			if (load.rzIn) begin
				zHi <= aluResult[2*`DP_WIDTH-1:`DP_WIDTH];
				zLo <= aluResult[`DP_WIDTH-1:0];
			end
		end
	end

	assign view.zHi    = zHi;
	assign view.zLo    = zLo;
	assign view.hi     = hi;
	assign view.lo     = lo;
	assign view.pc     = pc;
	assign view.mdr    = mdr;
	assign view.inport = inport;

endmodule

// ==== hw/dataPath.sv ====
`include "datapath_cfg.svh"

module dataPath (
	input  logic                        clock,
	input  logic                        rstN,
	input  datapath_pkg::controlWord_s  ctrl,
	input  logic [`DP_WIDTH-1:0]        memData,
	input  logic [`DP_WIDTH-1:0]        inportData,
	output logic [`DP_WIDTH-1:0]        marAddr,
	output logic [`DP_WIDTH-1:0]        outportData,
	output logic [`DP_WIDTH-1:0]        busValue
);

	logic [`DP_NREGS-1:0]          regWrEn;
	logic [$clog2(`DP_NREGS)-1:0]  regRdSel;
	logic                          regRdValid;
	logic [`DP_WIDTH-1:0]          regRdData;
	logic [`DP_WIDTH-1:0]          cSignExt;
	logic [`DP_WIDTH-1:0]          ry;
	logic [2*`DP_WIDTH-1:0]        aluResult;
	datapath_pkg::irWord_u         irWord;
	datapath_pkg::specialView_s    view;

	// The bus itself doubles as an observation port
	busMux uBusMux (
		.bus        (busValue),
		.outStrobe  (ctrl.outStrobe),
		.regRdValid (regRdValid),
		.regRdData  (regRdData),
		.special    (view),
		.cSignExt   (cSignExt)
	);

	selectEncode uSelectEncode (
		.ir        (irWord),
		.regStrobe (ctrl.regStrobe),
		.wrEn      (regWrEn),
		.rdSel     (regRdSel),
		.rdValid   (regRdValid),
		.cSignExt  (cSignExt)
	);

	registerFile uRegisterFile (
		.clock  (clock),
		.rstN   (rstN),
		.wrEn   (regWrEn),
		.rdSel  (regRdSel),
		.baOut  (ctrl.regStrobe.baOut),
		.bus    (busValue),
		.rdData (regRdData)
	);

	// RY on the A side, the bus on the B side
	alu uAlu (
		.a      (ry),
		.b      (busValue),
		.op     (ctrl.aluOp),
		.incPc  (ctrl.loadStrobe.incPc),
		.result (aluResult)
	);

	specialRegs uSpecialRegs (
		.clock       (clock),
		.rstN        (rstN),
		.load        (ctrl.loadStrobe),
		.memRead     (ctrl.memRead),
		.bus         (busValue),
		.memData     (memData),
		.inportData  (inportData),
		.aluResult   (aluResult),
		.ir          (irWord),
		.ry          (ry),
		.view        (view),
		.marAddr     (marAddr),
		.outportData (outportData)
	);

endmodule

// ==== bench/clockGen.sv ====
module clockGen (
	output logic clock,
	output logic rstN
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HalfPeriod  = 5;
	localparam int ResetCycles = 10;

	initial begin
		clock = 1'b0;
		forever #HalfPeriod clock = ~clock;
	end

	// Reset released on a rising edge, like any other stimulus
	initial begin
		rstN = 1'b0;
		repeat (ResetCycles) @(posedge clock);
		rstN <= 1'b1;
	end

endmodule

// ==== bench/busMonitor.sv ====
module busMonitor (
	input  logic        clock,
	input  logic        recValid,
	input  logic        lastInTest,
	input  logic [127:0] testName,
	input  logic [31:0] expBus,
	input  logic [31:0] expMar,
	input  logic [31:0] expOut,
	input  logic [2:0]  checkMask,
	input  logic [31:0] busValue,
	input  logic [31:0] marAddr,
	input  logic [31:0] outportData,
	input  logic        done,
	output int          testCount,
	output int          failedTests,
	output int          mismatches
);
	timeunit 1ns;
	timeprecision 100ps;

	int checkCount     = 0;
	int testMismatches = 0;
	bit reported       = 1'b0;

	initial begin
		testCount   = 0;
		failedTests = 0;
		mismatches  = 0;
	end

	// Name is packed right-justified, skip the empty leading bytes
	function automatic string nameText(input logic [127:0] raw);
		string text;

		text = "";
		for (int i = 15; i >= 0; i--) begin
			if (raw[i*8 +: 8] != 8'h00) text = {text, string'(raw[i*8 +: 8])};
		end
		return text;
	endfunction

	task automatic compareWord(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			mismatches++;
			testMismatches++;
			$display("Error in %0s: %0s expected %08h, actual %08h", nameText(testName),
				what, expected, actual);
		end
	endtask

	// Mid-cycle sample, bus and outputs are settled by then
	always @(negedge clock) begin
		if (recValid) begin
			if (checkMask[0]) compareWord("busValue", expBus, busValue);
			if (checkMask[1]) compareWord("marAddr", expMar, marAddr);
			if (checkMask[2]) compareWord("outportData", expOut, outportData);
			if (lastInTest) begin
				testCount++;
				if (testMismatches == 0) begin
					$display("Test %0s passed", nameText(testName));
				end else begin
					failedTests++;
					$display("Test %0s failed with %0d mismatches", nameText(testName),
						testMismatches);
				end
				testMismatches = 0;
			end
		end
		if (done && !reported) begin
			reported = 1'b1;
			$display("Tests run %0d, passed %0d, failed %0d; %0d checks, %0d mismatches",
				testCount, testCount - failedTests, failedTests, checkCount, mismatches);
		end
	end

endmodule

// ==== bench/dataPath_checker.sv ====
`include "datapath_cfg.svh"

module dataPathChecker (
	input logic                       clock,
	input logic                       rstN,
	input datapath_pkg::outStrobe_s   outStrobe,
	input datapath_pkg::regStrobe_s   regStrobe,
	input logic                       rzIn,
	input logic [`DP_WIDTH-1:0]       zHi,
	input logic [`DP_WIDTH-1:0]       zLo,
	input logic [`DP_WIDTH-1:0]       busValue,
	input logic [`DP_WIDTH-1:0]       marAddr,
	input logic [`DP_WIDTH-1:0]       outportData
);
	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0;

	// A register read is one more bus source
	oneBusSource: assert property (@(posedge clock) disable iff (!rstN)
		$onehot0({outStrobe, regStrobe.rOut | regStrobe.baOut}))
		else begin
			failCount++;
			$error("More than one source drives the bus in the same cycle");
		end

	resetClear: assert property (@(posedge clock)
		$rose(rstN) |-> busValue == '0 && marAddr == '0 && outportData == '0)
		else begin
			failCount++;
			$error("Outputs are not zero in the first cycle after reset");
		end

	zHold: assert property (@(posedge clock) disable iff (!rstN)
		!rzIn |=> $stable(zHi) && $stable(zLo))
		else begin
			failCount++;
			$error("Z changed without rzIn in the previous cycle");
		end

endmodule

// Sees the bus select strobes and the special registers from the top level
bind dataPath dataPathChecker uChecker (
	.clock       (clock),
	.rstN        (rstN),
	.outStrobe   (ctrl.outStrobe),
	.regStrobe   (ctrl.regStrobe),
	.rzIn        (ctrl.loadStrobe.rzIn),
	.zHi         (view.zHi),
	.zLo         (view.zLo),
	.busValue    (busValue),
	.marAddr     (marAddr),
	.outportData (outportData)
);

// ==== bench/dataPathTb.sv ====
`include "datapath_cfg.svh"

module dataPathTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MaxLines    = 256;
	// Reset and drain margin on top of one cycle per trace line
	localparam int SpareCycles = 20;

	logic                       clock;
	logic                       rstN;
	datapath_pkg::controlWord_s ctrl;
	logic [`DP_WIDTH-1:0]       memData;
	logic [`DP_WIDTH-1:0]       inportData;
	logic [`DP_WIDTH-1:0]       marAddr;
	logic [`DP_WIDTH-1:0]       outportData;
	logic [`DP_WIDTH-1:0]       busValue;

	// Record of the line now on the DUT inputs
	logic                       recValid;
	logic                       recLast;
	logic [127:0]               recName;
	logic [`DP_WIDTH-1:0]       recBus;
	logic [`DP_WIDTH-1:0]       recMar;
	logic [`DP_WIDTH-1:0]       recOut;
	logic [2:0]                 recMask;
	logic                       done;

	int testCount;
	int failedTests;
	int mismatches;

	datapath_pkg::controlWord_s ctrlWords [MaxLines];
	logic [127:0]               names     [MaxLines];
	logic [`DP_WIDTH-1:0]       memWords  [MaxLines];
	logic [`DP_WIDTH-1:0]       inWords   [MaxLines];
	logic [`DP_WIDTH-1:0]       expBus    [MaxLines];
	logic [`DP_WIDTH-1:0]       expMar    [MaxLines];
	logic [`DP_WIDTH-1:0]       expOut    [MaxLines];
	logic [2:0]                 masks     [MaxLines];
	logic                       lastFlags [MaxLines];

	int lineCount     = 0;
	int loadErrors    = 0;
	int expectedTests = 0;
	int cycleCount    = 0;
	int cycleLimit    = 0;

	clockGen uClockGen (
		.clock (clock),
		.rstN  (rstN)
	);

	dataPath DUT (
		.clock       (clock),
		.rstN        (rstN),
		.ctrl        (ctrl),
		.memData     (memData),
		.inportData  (inportData),
		.marAddr     (marAddr),
		.outportData (outportData),
		.busValue    (busValue)
	);

	busMonitor uBusMonitor (
		.clock       (clock),
		.recValid    (recValid),
		.lastInTest  (recLast),
		.testName    (recName),
		.expBus      (recBus),
		.expMar      (recMar),
		.expOut      (recOut),
		.checkMask   (recMask),
		.busValue    (busValue),
		.marAddr     (marAddr),
		.outportData (outportData),
		.done        (done),
		.testCount   (testCount),
		.failedTests (failedTests),
		.mismatches  (mismatches)
	);

	task automatic loadTrace();
		int fd;
		int fields;
		string line;
		logic [127:0] nameRaw;
		logic [7:0] regS;
		logic [11:0] loadS;
		logic [7:0] outS;
		logic [3:0] memRd;
		logic [7:0] op;
		logic [31:0] memW;
		logic [31:0] inW;
		logic [31:0] eBus;
		logic [31:0] eMar;
		logic [31:0] eOut;
		logic [3:0] mask;
		datapath_pkg::controlWord_s word;

		fd = $fopen("bench/datapath_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file bench/datapath_trace.txt");
			loadErrors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			fields = $fgets(line, fd);
			if (fields == 0) break;
			if (line.len() < 2 || line.getc(0) == "#") continue;
			fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", nameRaw, regS,
				loadS, outS, memRd, op, memW, inW, eBus, eMar, eOut, mask);
			if (fields <= 0) continue;
			if (fields != 12 || lineCount == MaxLines) begin
				$display("Trace line was not usable: %s", line);
				loadErrors++;
				continue;
			end
			word            = '0;
			word.regStrobe  = regS[5:0];
			word.loadStrobe = loadS[10:0];
			word.outStrobe  = outS;
			word.memRead    = memRd[0];
			word.aluOp      = datapath_pkg::aluOp_e'(op[4:0]);
			ctrlWords[lineCount] = word;
			names[lineCount]     = nameRaw;
			memWords[lineCount]  = memW;
			inWords[lineCount]   = inW;
			expBus[lineCount]    = eBus;
			expMar[lineCount]    = eMar;
			expOut[lineCount]    = eOut;
			masks[lineCount]     = mask[2:0];
			lineCount++;
		end
		$fclose(fd);

		// A test ends where the next line carries another name
		for (int i = 0; i < lineCount; i++) begin
			lastFlags[i] = (i == lineCount - 1) || (names[i + 1] != names[i]);
			if (lastFlags[i]) expectedTests++;
		end
	endtask

	task automatic driveLine(input int idx);
		ctrl       <= ctrlWords[idx];
		memData    <= memWords[idx];
		inportData <= inWords[idx];
		recValid   <= 1'b1;
		recLast    <= lastFlags[idx];
		recName    <= names[idx];
		recBus     <= expBus[idx];
		recMar     <= expMar[idx];
		recOut     <= expOut[idx];
		recMask    <= masks[idx];
	endtask

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("Timeout: the run went past %0d cycles without finishing", cycleLimit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin
		ctrl       = '0;
		memData    = '0;
		inportData = '0;
		recValid   = 1'b0;
		recLast    = 1'b0;
		recName    = '0;
		recBus     = '0;
		recMar     = '0;
		recOut     = '0;
		recMask    = '0;
		done       = 1'b0;

		loadTrace();
		cycleLimit = lineCount + SpareCycles;

		wait (rstN === 1'b1);
		for (int i = 0; i < lineCount; i++) begin
			@(posedge clock);
			driveLine(i);
		end

		// Idle the DUT and let the monitor close its report
		@(posedge clock);
		ctrl     <= '0;
		memData  <= '0;
		recValid <= 1'b0;
		done     <= 1'b1;
		@(posedge clock);

		if (loadErrors == 0 && lineCount > 0 && testCount == expectedTests &&
				failedTests == 0 && mismatches == 0 && DUT.uChecker.failCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== bench/datapath_trace.txt ====
# name regStrobe loadStrobe outStrobe memRead aluOp memData inportData expBus expMar expOut mask
# all fields hex except name; mask bit0 bus, bit1 marAddr, bit2 outportData
reset     00 000 00 0 00 00000000 00000000 00000000 00000000 00000000 7
memLoad   00 008 00 1 00 00918005 00000000 00000000 00000000 00000000 7
memLoad   00 208 04 1 00 CAFE1234 00000000 00918005 00000000 00000000 7
memLoad   0C 000 04 0 00 00000000 00000000 CAFE1234 00000000 00000000 7
memLoad   0A 000 00 0 00 00000000 00000000 CAFE1234 00000000 00000000 7
aluOps    00 008 00 1 00 8000000B 00000000 00000000 00000000 00000000 7
aluOps    00 108 04 1 00 00000004 00000000 8000000B 00000000 00000000 7
aluOps    24 008 04 1 00 0F0F0F0F 00000000 00000004 00000000 00000000 7
aluOps    14 000 04 0 00 00000000 00000000 0F0F0F0F 00000000 00000000 7
aluOps    12 080 00 0 01 00000000 00000000 0F0F0F0F 00000000 00000000 7
aluOps    00 000 10 0 00 00000000 00000000 70F0F0FC 00000000 00000000 7
aluOps    12 080 00 0 02 00000000 00000000 0F0F0F0F 00000000 00000000 7
aluOps    00 000 10 0 00 00000000 00000000 0000000B 00000000 00000000 7
aluOps    12 080 00 0 03 00000000 00000000 0F0F0F0F 00000000 00000000 7
aluOps    00 000 10 0 00 00000000 00000000 8F0F0F0F 00000000 00000000 7
aluOps    22 080 00 0 04 00000000 00000000 00000004 00000000 00000000 7
aluOps    00 000 10 0 00 00000000 00000000 08000000 00000000 00000000 7
aluOps    22 080 00 0 05 00000000 00000000 00000004 00000000 00000000 7
aluOps    00 000 10 0 00 00000000 00000000 F8000000 00000000 00000000 7
aluOps    22 080 00 0 06 00000000 00000000 00000004 00000000 00000000 7
aluOps    00 000 10 0 00 00000000 00000000 000000B0 00000000 00000000 7
aluOps    22 080 00 0 07 00000000 00000000 00000004 00000000 00000000 7
aluOps    00 000 10 0 00 00000000 00000000 B8000000 00000000 00000000 7
aluOps    22 080 00 0 08 00000000 00000000 00000004 00000000 00000000 7
aluOps    00 000 10 0 00 00000000 00000000 000000B8 00000000 00000000 7
aluOps    12 080 00 0 0B 00000000 00000000 0F0F0F0F 00000000 00000000 7
aluOps    00 000 10 0 00 00000000 00000000 F0F0F0F1 00000000 00000000 7
aluOps    00 000 20 0 00 00000000 00000000 00000000 00000000 00000000 7
mulDiv    00 00C 00 1 00 FFFE7960 00030000 00000000 00000000 00000000 7
mulDiv    00 100 04 0 00 00000000 00000000 FFFE7960 00000000 00000000 7
mulDiv    00 084 02 0 09 00000000 00000007 00030000 00000000 00000000 7
mulDiv    00 040 20 0 00 00000000 00000000 FFFFFFFB 00000000 00000000 7
mulDiv    00 020 10 0 00 00000000 00000000 6C200000 00000000 00000000 7
mulDiv    00 000 80 0 00 00000000 00000000 FFFFFFFB 00000000 00000000 7
mulDiv    00 000 40 0 00 00000000 00000000 6C200000 00000000 00000000 7
mulDiv    00 080 02 0 0A 00000000 00000000 00000007 00000000 00000000 7
mulDiv    00 000 20 0 00 00000000 00000000 FFFFFFFB 00000000 00000000 7
mulDiv    00 000 10 0 00 00000000 00000000 FFFFC833 00000000 00000000 7
mulDiv    00 080 00 0 0A 00000000 00000000 00000000 00000000 00000000 7
mulDiv    00 000 20 0 00 00000000 00000000 FFFE7960 00000000 00000000 7
mulDiv    00 000 10 0 00 00000000 00000000 FFFFFFFF 00000000 00000000 7
immediate 00 008 01 1 00 002C00F0 00000000 00018005 00000000 00000000 7
immediate 00 200 04 0 00 00000000 00000000 002C00F0 00000000 00000000 7
immediate 24 000 01 0 00 00000000 00000000 FFFC00F0 00000000 00000000 7
immediate 22 000 00 0 00 00000000 00000000 FFFC00F0 00000000 00000000 7
immediate 21 000 00 0 00 00000000 00000000 00000000 00000000 00000000 7
pcPorts   00 008 00 1 00 00000FFF 00000000 00000000 00000000 00000000 7
pcPorts   00 400 04 0 00 00000000 00000000 00000FFF 00000000 00000000 7
pcPorts   00 091 08 0 0C 00000000 00000000 00000FFF 00000000 00000000 7
pcPorts   00 400 10 0 00 00000000 00000000 00001000 00000FFF 00000000 7
pcPorts   00 002 08 0 00 00000000 00000000 00001000 00000FFF 00000000 7
pcPorts   00 004 00 0 00 00000000 A5A55A5A 00000000 00000FFF 00001000 7
pcPorts   00 010 02 0 00 00000000 00000000 A5A55A5A 00000FFF 00001000 7
idle      00 000 00 0 00 00000000 00000000 00000000 A5A55A5A 00001000 7

// ==== build.f ====
+incdir+hw
hw/datapath_pkg.sv
hw/busMux.sv
hw/registerFile.sv
hw/selectEncode.sv
hw/alu.sv
hw/specialRegs.sv
hw/dataPath.sv
bench/clockGen.sv
bench/busMonitor.sv
bench/dataPath_checker.sv
bench/dataPathTb.sv
